/* verilog/mvu_csr_pkg.sv */
`default_nettype none

package mvu_csr_pkg;

    // array size and bus widths
    localparam int NMVU           = 4;
    localparam int BMVUA          = 4;
    localparam int BUIDX          = $clog2(NMVU);
    localparam int APB_ADDR_WIDTH = 16;
    localparam int APB_DATA_WIDTH = 32;
    localparam int BOFFSET        = 12;

    // operands and loop table depths
    localparam int NOPER    = 3;
    localparam int NJUMPS   = 5;
    localparam int NLENGTHS = 4;
    localparam int BSLOT    = $clog2(NJUMPS);

    // field widths
    localparam int BBWADDR  = 9;
    localparam int BBDADDR  = 9;
    localparam int BJUMP    = 15;
    localparam int BLENGTH  = 15;
    localparam int BPREC    = 6;
    localparam int BCNTDWN  = 29;
    localparam int BQMSBIDX = 5;

    // field positions
    localparam int PREC_WSIGNED_BIT = 24;
    localparam int PREC_DSIGNED_BIT = 25;
    localparam int CMD_MAXEN_BIT    = 29;
    localparam int CMD_MULMODE_LSB  = 30;

    // word offsets within one unit
    typedef enum logic [BOFFSET-1:0] {
        CSR_WBASE     = 12'h000,
        CSR_IBASE     = 12'h004,
        CSR_OBASE     = 12'h008,
        CSR_WJUMP_0   = 12'h00C,
        CSR_WJUMP_1   = 12'h010,
        CSR_WJUMP_2   = 12'h014,
        CSR_WJUMP_3   = 12'h018,
        CSR_WJUMP_4   = 12'h01C,
        CSR_IJUMP_0   = 12'h020,
        CSR_IJUMP_1   = 12'h024,
        CSR_IJUMP_2   = 12'h028,
        CSR_IJUMP_3   = 12'h02C,
        CSR_IJUMP_4   = 12'h030,
        CSR_OJUMP_0   = 12'h034,
        CSR_OJUMP_1   = 12'h038,
        CSR_OJUMP_2   = 12'h03C,
        CSR_OJUMP_3   = 12'h040,
        CSR_OJUMP_4   = 12'h044,
        CSR_WLENGTH_1 = 12'h048,
        CSR_WLENGTH_2 = 12'h04C,
        CSR_WLENGTH_3 = 12'h050,
        CSR_WLENGTH_4 = 12'h054,
        CSR_ILENGTH_1 = 12'h058,
        CSR_ILENGTH_2 = 12'h05C,
        CSR_ILENGTH_3 = 12'h060,
        CSR_ILENGTH_4 = 12'h064,
        CSR_OLENGTH_1 = 12'h068,
        CSR_OLENGTH_2 = 12'h06C,
        CSR_OLENGTH_3 = 12'h070,
        CSR_OLENGTH_4 = 12'h074,
        CSR_PRECISION = 12'h078,
        CSR_COMMAND   = 12'h07C,
        CSR_QUANT     = 12'h080
    } csr_offset_e;

    typedef enum logic [2:0] {
        GRP_NONE,
        GRP_BASE,
        GRP_JUMP,
        GRP_LENGTH,
        GRP_PREC,
        GRP_COMMAND,
        GRP_QUANT
    } csr_group_e;

    typedef enum logic [1:0] {
        OPER_W,
        OPER_I,
        OPER_O
    } operand_e;

    typedef logic [BJUMP-1:0]   jump_t;
    typedef logic [BLENGTH-1:0] length_t;

    typedef struct packed {
        logic                      wr;
        logic                      rd;
        logic [BMVUA-1:0]          unit;
        csr_group_e                group;
        operand_e                  oper;
        logic [BSLOT-1:0]          slot;
        logic                      mapped;
        logic [APB_DATA_WIDTH-1:0] wdata;
    } csr_access_t;

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [APB_ADDR_WIDTH-1:0] paddr;
        logic [APB_DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_WIDTH-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic             d_signed;
        logic             w_signed;
        logic [BPREC-1:0] oprec;
        logic [BPREC-1:0] iprec;
        logic [BPREC-1:0] wprec;
    } precision_t;

    typedef struct packed {
        logic [1:0]         mul_mode;
        logic               max_en;
        logic [BCNTDWN-1:0] countdown;
    } command_t;

    typedef struct packed {
        logic [BBWADDR-1:0]  wbase;
        logic [BBDADDR-1:0]  ibase;
        logic [BBDADDR-1:0]  obase;
        precision_t          prec;
        command_t            cmd;
        logic [BQMSBIDX-1:0] quant_msbidx;
    } unit_cfg_t;

endpackage

`default_nettype wire

/* verilog/apb_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_decode (
    input  mvu_csr_pkg::apb_req_t    apb_req,
    output mvu_csr_pkg::csr_access_t access
);
    import mvu_csr_pkg::*;

    logic               access_phase;
    logic [BMVUA-1:0]   unit_id;
    logic [BOFFSET-1:0] offset_bits;
    csr_offset_e        offset;
    csr_group_e         group;
    operand_e           oper;
    logic [BOFFSET-1:0] run_start;
    logic [BOFFSET-1:0] slot_diff;
    logic               mapped;

    assign access_phase = apb_req.psel && apb_req.penable;
    assign unit_id      = apb_req.paddr[APB_ADDR_WIDTH-1 -: BMVUA];
    assign offset_bits  = apb_req.paddr[BOFFSET-1:0];
    assign offset       = csr_offset_e'(offset_bits);

    // run_start is the first offset of a table run, so the slot is the word distance to it
    always_comb begin
        group     = GRP_NONE;
        oper      = OPER_W;
        run_start = offset_bits;
        unique case (offset)
            CSR_WBASE: begin
                group = GRP_BASE;
                oper  = OPER_W;
            end
            CSR_IBASE: begin
                group = GRP_BASE;
                oper  = OPER_I;
            end
            CSR_OBASE: begin
                group = GRP_BASE;
                oper  = OPER_O;
            end
            CSR_WJUMP_0, CSR_WJUMP_1, CSR_WJUMP_2, CSR_WJUMP_3, CSR_WJUMP_4: begin
                group     = GRP_JUMP;
                oper      = OPER_W;
                run_start = CSR_WJUMP_0;
            end
            CSR_IJUMP_0, CSR_IJUMP_1, CSR_IJUMP_2, CSR_IJUMP_3, CSR_IJUMP_4: begin
                group     = GRP_JUMP;
                oper      = OPER_I;
                run_start = CSR_IJUMP_0;
            end
            CSR_OJUMP_0, CSR_OJUMP_1, CSR_OJUMP_2, CSR_OJUMP_3, CSR_OJUMP_4: begin
                group     = GRP_JUMP;
                oper      = OPER_O;
                run_start = CSR_OJUMP_0;
            end
            // length slot 1 lands on table entry 0
            CSR_WLENGTH_1, CSR_WLENGTH_2, CSR_WLENGTH_3, CSR_WLENGTH_4: begin
                group     = GRP_LENGTH;
                oper      = OPER_W;
                run_start = CSR_WLENGTH_1;
            end
            CSR_ILENGTH_1, CSR_ILENGTH_2, CSR_ILENGTH_3, CSR_ILENGTH_4: begin
                group     = GRP_LENGTH;
                oper      = OPER_I;
                run_start = CSR_ILENGTH_1;
            end
            CSR_OLENGTH_1, CSR_OLENGTH_2, CSR_OLENGTH_3, CSR_OLENGTH_4: begin
                group     = GRP_LENGTH;
                oper      = OPER_O;
                run_start = CSR_OLENGTH_1;
            end
            CSR_PRECISION: group = GRP_PREC;
            CSR_COMMAND:   group = GRP_COMMAND;
            CSR_QUANT:     group = GRP_QUANT;
            default:       group = GRP_NONE;
        endcase
    end

    assign slot_diff = offset_bits - run_start;

    // unknown offsets and absent units are both unmapped
    assign mapped = (group != GRP_NONE) && (unit_id < BMVUA'(NMVU));

    assign access = '{
        wr:     access_phase && apb_req.pwrite,
        rd:     access_phase && !apb_req.pwrite,
        unit:   unit_id,
        group:  group,
        oper:   oper,
        slot:   slot_diff[2 +: BSLOT],
        mapped: mapped,
        wdata:  apb_req.pwdata
    };

endmodule

`default_nettype wire

/* verilog/stride_table.sv */
`timescale 1ns/100ps
`default_nettype none

module stride_table #(
    parameter type                     entry_t = mvu_csr_pkg::jump_t,
    parameter int                      DEPTH   = mvu_csr_pkg::NJUMPS,
    parameter mvu_csr_pkg::csr_group_e GROUP   = mvu_csr_pkg::GRP_JUMP
) (
    input  logic                                   mvu_ext_if,
    input  logic                                   rst_n,
    input  mvu_csr_pkg::csr_access_t               access,
    output entry_t [mvu_csr_pkg::NMVU-1:0][mvu_csr_pkg::NOPER-1:0][DEPTH-1:0] entries,
    output logic [mvu_csr_pkg::APB_DATA_WIDTH-1:0] rdata
);
    import mvu_csr_pkg::*;

    localparam int EBITS = $bits(entry_t);
    localparam int BIDX  = $clog2(DEPTH);

    logic             hit;
    logic [BUIDX-1:0] unit_idx;
    logic [BIDX-1:0]  slot_idx;
    entry_t           wr_entry;

    assign hit      = access.mapped && (access.group == GROUP);
    assign unit_idx = access.unit[BUIDX-1:0];
    assign slot_idx = access.slot[BIDX-1:0];

    // upper write data bits beyond the entry width are dropped
    assign wr_entry = entry_t'(access.wdata[EBITS-1:0]);

    always_ff @(posedge mvu_ext_if) begin
        if (!rst_n) begin
            entries <= '0;
        end else if (access.wr && hit) begin
            entries[unit_idx][access.oper][slot_idx] <= wr_entry;
        end
    end

    // the bank only looks at this word when the group matches
    assign rdata = APB_DATA_WIDTH'(entries[unit_idx][access.oper][slot_idx]);

endmodule

`default_nettype wire

/* verilog/unit_csr_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module unit_csr_bank (
    input  logic                                   mvu_ext_if,
    input  logic                                   rst_n,
    input  mvu_csr_pkg::csr_access_t               access,
    input  logic [mvu_csr_pkg::APB_DATA_WIDTH-1:0] jump_rdata,
    input  logic [mvu_csr_pkg::APB_DATA_WIDTH-1:0] length_rdata,
    output mvu_csr_pkg::apb_rsp_t                  apb_rsp,
    output logic [mvu_csr_pkg::NMVU-1:0]           start,
    output mvu_csr_pkg::unit_cfg_t [mvu_csr_pkg::NMVU-1:0] cfg
);
    import mvu_csr_pkg::*;

    logic [BUIDX-1:0]          unit_idx;
    logic                      wr_hit;
    logic                      cmd_wr;
    logic [NMVU-1:0]           start_nxt;
    unit_cfg_t                 sel_cfg;
    logic [APB_DATA_WIDTH-1:0] reg_rdata;
    logic [APB_DATA_WIDTH-1:0] rdata;

    assign unit_idx = access.unit[BUIDX-1:0];
    assign wr_hit   = access.wr && access.mapped;
    assign cmd_wr   = wr_hit && (access.group == GRP_COMMAND);

    always_ff @(posedge mvu_ext_if) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (wr_hit) begin
            case (access.group)
                GRP_BASE: begin
                    case (access.oper)
                        OPER_W:  cfg[unit_idx].wbase <= access.wdata[BBWADDR-1:0];
                        OPER_I:  cfg[unit_idx].ibase <= access.wdata[BBDADDR-1:0];
                        OPER_O:  cfg[unit_idx].obase <= access.wdata[BBDADDR-1:0];
                        default: ;
                    endcase
                end
                GRP_PREC: begin
                    cfg[unit_idx].prec.wprec    <= access.wdata[BPREC-1:0];
                    cfg[unit_idx].prec.iprec    <= access.wdata[2*BPREC-1:BPREC];
                    cfg[unit_idx].prec.oprec    <= access.wdata[3*BPREC-1:2*BPREC];
                    cfg[unit_idx].prec.w_signed <= access.wdata[PREC_WSIGNED_BIT];
                    cfg[unit_idx].prec.d_signed <= access.wdata[PREC_DSIGNED_BIT];
                end
                GRP_COMMAND: begin
                    cfg[unit_idx].cmd.countdown <= access.wdata[BCNTDWN-1:0];
                    cfg[unit_idx].cmd.max_en    <= access.wdata[CMD_MAXEN_BIT];
                    cfg[unit_idx].cmd.mul_mode  <= access.wdata[CMD_MULMODE_LSB +: 2];
                end
                GRP_QUANT: begin
                    cfg[unit_idx].quant_msbidx <= access.wdata[BQMSBIDX-1:0];
                end
                // table groups are held in the stride tables
                default: ;
            endcase
        end
    end

    // one pulse per command write and only for the addressed unit
    always_comb begin
        for (int i = 0; i < NMVU; i++) begin
            start_nxt[i] = cmd_wr && (unit_idx == BUIDX'(i));
        end
    end

    always_ff @(posedge mvu_ext_if) begin
        if (!rst_n) begin
            start <= '0;
        end else begin
            start <= start_nxt;
        end
    end

    assign sel_cfg = cfg[unit_idx];

    // unused register bits stay 0
    always_comb begin
        reg_rdata = '0;
        case (access.group)
            GRP_BASE: begin
                case (access.oper)
                    OPER_W:  reg_rdata[BBWADDR-1:0] = sel_cfg.wbase;
                    OPER_I:  reg_rdata[BBDADDR-1:0] = sel_cfg.ibase;
                    OPER_O:  reg_rdata[BBDADDR-1:0] = sel_cfg.obase;
                    default: reg_rdata = '0;
                endcase
            end
            GRP_JUMP:   reg_rdata = jump_rdata;
            GRP_LENGTH: reg_rdata = length_rdata;
            GRP_PREC: begin
                reg_rdata[BPREC-1:0]         = sel_cfg.prec.wprec;
                reg_rdata[2*BPREC-1:BPREC]   = sel_cfg.prec.iprec;
                reg_rdata[3*BPREC-1:2*BPREC] = sel_cfg.prec.oprec;
                reg_rdata[PREC_WSIGNED_BIT]  = sel_cfg.prec.w_signed;
                reg_rdata[PREC_DSIGNED_BIT]  = sel_cfg.prec.d_signed;
            end
            GRP_COMMAND: begin
                reg_rdata[BCNTDWN-1:0]          = sel_cfg.cmd.countdown;
                reg_rdata[CMD_MAXEN_BIT]        = sel_cfg.cmd.max_en;
                reg_rdata[CMD_MULMODE_LSB +: 2] = sel_cfg.cmd.mul_mode;
            end
            GRP_QUANT:  reg_rdata[BQMSBIDX-1:0] = sel_cfg.quant_msbidx;
            default:    reg_rdata = '0;
        endcase
    end

    always_comb begin
        if (!access.rd) begin
            rdata = '0;
        end else if (!access.mapped) begin
            rdata = '1;
        end else begin
            rdata = reg_rdata;
        end
    end

    // zero wait states and never an error
    assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};

endmodule

`default_nettype wire

/* verilog/mvu_csr_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mvu_csr_top (
    input  logic                           mvu_ext_if,
    input  logic                           rst_n,
    input  mvu_csr_pkg::apb_req_t          apb_req,
    output mvu_csr_pkg::apb_rsp_t          apb_rsp,
    output logic [mvu_csr_pkg::NMVU-1:0]   start,
    output mvu_csr_pkg::unit_cfg_t [mvu_csr_pkg::NMVU-1:0] cfg,
    output mvu_csr_pkg::jump_t
        [mvu_csr_pkg::NMVU-1:0][mvu_csr_pkg::NOPER-1:0][mvu_csr_pkg::NJUMPS-1:0] jumps,
    output mvu_csr_pkg::length_t
        [mvu_csr_pkg::NMVU-1:0][mvu_csr_pkg::NOPER-1:0][mvu_csr_pkg::NLENGTHS-1:0] lengths
);
    import mvu_csr_pkg::*;

    csr_access_t               access;
    logic [APB_DATA_WIDTH-1:0] jump_rdata;
    logic [APB_DATA_WIDTH-1:0] length_rdata;

    apb_decode decode0 (
        .apb_req (apb_req),
        .access  (access)
    );

    stride_table #(
        .entry_t (jump_t),
        .DEPTH   (NJUMPS),
        .GROUP   (GRP_JUMP)
    ) jump_table (
        .mvu_ext_if (mvu_ext_if),
        .rst_n      (rst_n),
        .access     (access),
        .entries    (jumps),
        .rdata      (jump_rdata)
    );

    stride_table #(
        .entry_t (length_t),
        .DEPTH   (NLENGTHS),
        .GROUP   (GRP_LENGTH)
    ) length_table (
        .mvu_ext_if (mvu_ext_if),
        .rst_n      (rst_n),
        .access     (access),
        .entries    (lengths),
        .rdata      (length_rdata)
    );

    unit_csr_bank bank0 (
        .mvu_ext_if   (mvu_ext_if),
        .rst_n        (rst_n),
        .access       (access),
        .jump_rdata   (jump_rdata),
        .length_rdata (length_rdata),
        .apb_rsp      (apb_rsp),
        .start        (start),
        .cfg          (cfg)
    );

endmodule

`default_nettype wire

/* test/mvu_csr_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module mvu_csr_chk (
    input logic                         mvu_ext_if,
    input logic                         rst_n,
    input mvu_csr_pkg::apb_req_t        apb_req,
    input mvu_csr_pkg::apb_rsp_t        apb_rsp,
    input logic [mvu_csr_pkg::NMVU-1:0] start
);
    import mvu_csr_pkg::*;

    logic read_phase;
    logic cmd_wr;

    assign read_phase = apb_req.psel && apb_req.penable && !apb_req.pwrite;

    // mapped command write in its access phase
    assign cmd_wr = apb_req.psel && apb_req.penable && apb_req.pwrite
        && (apb_req.paddr[BOFFSET-1:0] == CSR_COMMAND)
        && (apb_req.paddr[APB_ADDR_WIDTH-1 -: BMVUA] < BMVUA'(NMVU));

    start_onehot: assert property (@(posedge mvu_ext_if) disable iff (!rst_n)
        $onehot0(start))
        else $error("start has more than one bit set");

    start_cause: assert property (@(posedge mvu_ext_if) disable iff (!rst_n)
        (|start) |-> $past(cmd_wr))
        else $error("start pulse without a command write in the previous cycle");

    rsp_const: assert property (@(posedge mvu_ext_if) disable iff (!rst_n)
        apb_rsp.pready && !apb_rsp.pslverr)
        else $error("pready low or pslverr high");

    prdata_idle: assert property (@(posedge mvu_ext_if) disable iff (!rst_n)
        !read_phase |-> (apb_rsp.prdata == '0))
        else $error("prdata not zero outside a read access phase");

endmodule

bind mvu_csr_top mvu_csr_chk chk0 (
    .mvu_ext_if (mvu_ext_if),
    .rst_n      (rst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .start      (start)
);

`default_nettype wire

/* test/mvu_csr_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mvu_csr_tb;
    import mvu_csr_pkg::*;

    localparam logic [1:0] OP_WR  = 2'd0;
    localparam logic [1:0] OP_RD  = 2'd1;
    localparam logic [1:0] OP_CMD = 2'd2;
    localparam logic [1:0] OP_CHK = 2'd3;

    // register index is the word offset
    localparam int IDX_JUMP   = CSR_WJUMP_0 >> 2;
    localparam int IDX_LENGTH = CSR_WLENGTH_1 >> 2;
    localparam int IDX_PREC   = CSR_PRECISION >> 2;
    localparam int IDX_CMD    = CSR_COMMAND >> 2;
    localparam int NREGS      = (CSR_QUANT >> 2) + 1;

    typedef struct packed {
        logic [1:0]         op;
        logic [BMVUA-1:0]   unit;
        logic [BOFFSET-1:0] offset;
        logic [31:0]        wdata;
        logic [31:0]        exp;
    } stim_t;

    logic      mvu_ext_if;
    logic      rst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    logic [NMVU-1:0] start;
    unit_cfg_t [NMVU-1:0] cfg;
    jump_t [NMVU-1:0][NOPER-1:0][NJUMPS-1:0]     jumps;
    length_t [NMVU-1:0][NOPER-1:0][NLENGTHS-1:0] lengths;

    stim_t       stim_q[$];
    logic [31:0] shadow[NMVU][NREGS];
    logic [31:0] cur[NMVU][NREGS];
    integer      seed;
    int          err_count[3];
    int          applied;
    bit          table_ready;

    mvu_csr_top dut0 (
        .mvu_ext_if (mvu_ext_if),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .start      (start),
        .cfg        (cfg),
        .jumps      (jumps),
        .lengths    (lengths)
    );

    always #5 mvu_ext_if = ~mvu_ext_if;

    function automatic logic [31:0] field_mask(input int bits);
        return (bits >= 32) ? 32'hFFFF_FFFF : ((32'd1 << bits) - 32'd1);
    endfunction

    function automatic bit is_mapped(input logic [BMVUA-1:0] unit,
                                     input logic [BOFFSET-1:0] offset);
        return (unit < NMVU) && (offset[1:0] == 2'b00) && (offset <= CSR_QUANT);
    endfunction

    // value a register returns after a write of wdata
    function automatic logic [31:0] readback(input logic [BOFFSET-1:0] offset,
                                             input logic [31:0] wdata);
        int          idx;
        logic [31:0] keep;
        idx = int'(offset >> 2);
        if (idx < IDX_JUMP) begin
            keep = field_mask((idx == 0) ? BBWADDR : BBDADDR);
        end else if (idx < IDX_PREC) begin
            keep = field_mask((idx < IDX_LENGTH) ? BJUMP : BLENGTH);
        end else if (idx == IDX_PREC) begin
            keep = field_mask(3 * BPREC) | (32'd1 << PREC_WSIGNED_BIT)
                | (32'd1 << PREC_DSIGNED_BIT);
        end else if (idx == IDX_CMD) begin
            keep = field_mask(BCNTDWN) | (32'd1 << CMD_MAXEN_BIT)
                | (32'd3 << CMD_MULMODE_LSB);
        end else begin
            keep = field_mask(BQMSBIDX);
        end
        return wdata & keep;
    endfunction

    task automatic add_entry(input logic [1:0] op, input int unit, input int offset);
        stim_t e;
        e.op     = op;
        e.unit   = unit[BMVUA-1:0];
        e.offset = offset[BOFFSET-1:0];
        e.wdata  = '0;
        e.exp    = '0;
        if (op == OP_WR || op == OP_CMD) begin
            e.wdata = $random(seed);
        end
        if (op == OP_RD) begin
            e.exp = 32'hFFFF_FFFF;
            if (is_mapped(e.unit, e.offset)) begin
                e.exp = shadow[unit][offset >> 2];
            end
        end else if (op != OP_CHK && is_mapped(e.unit, e.offset)) begin
            e.exp = readback(e.offset, e.wdata);
            shadow[unit][offset >> 2] = e.exp;
        end
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        int bad_unit[3];
        int bad_offset[4];
        bad_unit   = '{4, 9, 15};
        bad_offset = '{12'h084, 12'h0FC, 12'h002, 12'hFFC};
        add_entry(OP_CHK, 0, 0);
        for (int u = 0; u < NMVU; u++) begin
            for (int r = 0; r < NREGS; r++) begin
                add_entry(OP_RD, u, r * 4);
            end
        end
        // distinct data in every register lets any cross-write show up on read-back
        for (int u = 0; u < NMVU; u++) begin
            for (int r = 0; r < NREGS; r++) begin
                add_entry((r == IDX_CMD) ? OP_CMD : OP_WR, u, r * 4);
            end
        end
        add_entry(OP_CHK, 0, 0);
        for (int u = 0; u < NMVU; u++) begin
            for (int r = 0; r < NREGS; r++) begin
                add_entry(OP_RD, u, r * 4);
            end
        end
        for (int u = 0; u < NMVU; u++) begin
            add_entry(OP_CMD, u, CSR_COMMAND);
            add_entry(OP_CMD, u, CSR_COMMAND);
            add_entry(OP_RD, u, CSR_COMMAND);
            add_entry(OP_WR, u, CSR_IJUMP_2);
            add_entry(OP_RD, u, CSR_IJUMP_2);
            add_entry(OP_RD, u, CSR_IJUMP_1);
        end
        foreach (bad_unit[i]) begin
            add_entry(OP_RD, bad_unit[i], CSR_WBASE);
            add_entry(OP_RD, bad_unit[i], CSR_COMMAND);
            add_entry(OP_WR, bad_unit[i], CSR_WBASE);
            add_entry(OP_CMD, bad_unit[i], CSR_COMMAND);
        end
        foreach (bad_offset[i]) begin
            add_entry(OP_RD, 1, bad_offset[i]);
            add_entry(OP_WR, 1, bad_offset[i]);
        end
        add_entry(OP_CHK, 0, 0);
        for (int r = 0; r < NREGS; r++) begin
            add_entry(OP_RD, 1, r * 4);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input int kind);
        assert (got === exp) else begin
            $display("Fail %s: expected %h, got %h", name, exp, got);
            err_count[kind]++;
        end
    endtask

    task automatic apb_write(input logic [BMVUA-1:0] unit, input logic [BOFFSET-1:0] offset,
                             input logic [31:0] data);
        @(negedge mvu_ext_if);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = {unit, offset};
        apb_req.pwdata  = data;
        @(negedge mvu_ext_if);
        apb_req.penable = 1'b1;
        @(negedge mvu_ext_if);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [BMVUA-1:0] unit, input logic [BOFFSET-1:0] offset,
                            output logic [31:0] data);
        @(negedge mvu_ext_if);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = {unit, offset};
        @(negedge mvu_ext_if);
        apb_req.penable = 1'b1;
        // zero-latency read data is sampled at the edge that ends the access
        @(posedge mvu_ext_if);
        data = apb_rsp.prdata;
        @(negedge mvu_ext_if);
        apb_req = '0;
    endtask

    // compare every output field with the expected register contents
    task automatic check_outputs();
        logic [31:0] prec_word;
        for (int u = 0; u < NMVU; u++) begin
            check_word($sformatf("cfg[%0d].wbase", u), 32'(cfg[u].wbase), cur[u][0], 1);
            check_word($sformatf("cfg[%0d].ibase", u), 32'(cfg[u].ibase), cur[u][1], 1);
            check_word($sformatf("cfg[%0d].obase", u), 32'(cfg[u].obase), cur[u][2], 1);
            prec_word                           = '0;
            prec_word[BPREC-1:0]                = cfg[u].prec.wprec;
            prec_word[2*BPREC-1:BPREC]          = cfg[u].prec.iprec;
            prec_word[3*BPREC-1:2*BPREC]        = cfg[u].prec.oprec;
            prec_word[PREC_WSIGNED_BIT]         = cfg[u].prec.w_signed;
            prec_word[PREC_DSIGNED_BIT]         = cfg[u].prec.d_signed;
            check_word($sformatf("cfg[%0d].prec", u), prec_word, cur[u][IDX_PREC], 1);
            check_word($sformatf("cfg[%0d].cmd", u), 32'(cfg[u].cmd), cur[u][IDX_CMD], 1);
            check_word($sformatf("cfg[%0d].quant_msbidx", u), 32'(cfg[u].quant_msbidx),
                       cur[u][NREGS-1], 1);
            for (int o = 0; o < NOPER; o++) begin
                for (int j = 0; j < NJUMPS; j++) begin
                    check_word($sformatf("jumps[%0d][%0d][%0d]", u, o, j), 32'(jumps[u][o][j]),
                               cur[u][IDX_JUMP + o * NJUMPS + j], 1);
                end
                for (int l = 0; l < NLENGTHS; l++) begin
                    check_word($sformatf("lengths[%0d][%0d][%0d]", u, o, l),
                               32'(lengths[u][o][l]), cur[u][IDX_LENGTH + o * NLENGTHS + l], 1);
                end
            end
        end
        check_word("start", 32'(start), '0, 2);
    endtask

    task automatic apply_entry(input stim_t e);
        logic [31:0]     got;
        logic [NMVU-1:0] pulse;
        pulse = '0;
        case (e.op)
            OP_RD: begin
                apb_read(e.unit, e.offset, got);
                check_word($sformatf("prdata[%h]", {e.unit, e.offset}), got, e.exp, 0);
            end
            OP_WR, OP_CMD: begin
                apb_write(e.unit, e.offset, e.wdata);
                if (is_mapped(e.unit, e.offset)) begin
                    cur[e.unit][e.offset >> 2] = e.exp;
                    if (e.op == OP_CMD) begin
                        pulse[e.unit[BUIDX-1:0]] = 1'b1;
                    end
                end
                check_word("start", 32'(start), 32'(pulse), 2);
                if (e.op == OP_CMD) begin
                    @(negedge mvu_ext_if);
                    check_word("start", 32'(start), '0, 2);
                end
            end
            default: check_outputs();
        endcase
    endtask

    initial begin
        mvu_ext_if  = 1'b0;
        rst_n       = 1'b0;
        apb_req     = '0;
        seed        = 32'h4d29;
        err_count   = '{0, 0, 0};
        applied     = 0;
        table_ready = 1'b0;
        for (int u = 0; u < NMVU; u++) begin
            for (int r = 0; r < NREGS; r++) begin
                shadow[u][r] = '0;
                cur[u][r]    = '0;
            end
        end
        build_table();
        table_ready = 1'b1;
        repeat (8) @(negedge mvu_ext_if);
        rst_n = 1'b1;
        foreach (stim_q[i]) begin
            apply_entry(stim_q[i]);
            applied++;
        end
        @(negedge mvu_ext_if);
        $display("errors: read %0d, output %0d, start %0d",
                 err_count[0], err_count[1], err_count[2]);
        if (err_count[0] + err_count[1] + err_count[2] == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // each entry needs at most 4 cycles
    initial begin
        wait (table_ready);
        #(stim_q.size() * 4 * 10 + 8 * 10 + 2000);
        $display("timeout: stimulus table stuck after %0d of %0d entries; errors: %0d",
                 applied, stim_q.size(), err_count[0] + err_count[1] + err_count[2]);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* mvu_csr_top.f */
verilog/mvu_csr_pkg.sv
verilog/apb_decode.sv
verilog/stride_table.sv
verilog/unit_csr_bank.sv
verilog/mvu_csr_top.sv
test/mvu_csr_chk.sv
test/mvu_csr_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the mvu_csr testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mvu_csr_tb \
    -f mvu_csr_top.f --Mdir obj_dir -o mvu_csr_sim \
    || { echo "compile failed"; exit 1; }

./obj_dir/mvu_csr_sim > sim.log 2>&1 \
    && cat sim.log \
    || { cat sim.log; echo "simulation ended with an error status"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "test failed"; exit 1; } || exit 0
